// File: spmm_top.f
spmm_pkg.sv
rhs_loader.sv
lhs_row_decoder.sv
column_pe.sv
result_collector.sv
spmm_top.sv
spmm_chk.sv
spmm_tb.sv

// File: spmm_tb.sv
`timescale 1ns/100ps

module spmm_tb
    import spmm_pkg::*;
();

    localparam int wait_limit = 64;

    logic                       clock;
    logic                       reset;
    logic                       rhs_valid;
    logic                       rhs_ready;
    logic [dim-1:0][data_w-1:0] rhs_row;
    logic                       lhs_valid;
    logic                       lhs_ready;
    logic [dim-1:0][data_w-1:0] lhs_data;
    logic [dim-1:0][idx_w-1:0]  lhs_col;
    logic [dim-1:0][ptr_w-1:0]  lhs_ptr;
    logic                       out_valid;
    logic                       out_ready;
    logic [dim-1:0][data_w-1:0] out_row;

    // Reference copy of the right matrix in row-major order
    logic [data_w-1:0] model_rhs [beats][dim];

    int errors;
    int failed_tests;
    int test_start;
    int chk_failures;

    spmm_top uut (
        .clock     (clock),
        .reset     (reset),
        .rhs_valid (rhs_valid),
        .rhs_ready (rhs_ready),
        .rhs_row   (rhs_row),
        .lhs_valid (lhs_valid),
        .lhs_ready (lhs_ready),
        .lhs_data  (lhs_data),
        .lhs_col   (lhs_col),
        .lhs_ptr   (lhs_ptr),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_row   (out_row)
    );

    bind spmm_top spmm_chk u_chk (
        .clock     (clock),
        .reset     (reset),
        .lhs_ready (lhs_ready),
        .rhs_ready (rhs_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_row   (out_row)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    // Streams a random right matrix one row per beat
    task automatic load_matrix(input bit first_load);
        int waited;
        for (int r = 0; r < beats; r++) begin
            @(posedge clock);
            rhs_valid <= 1'b1;
            for (int j = 0; j < dim; j++) begin
                model_rhs[r][j] = data_w'($urandom);
                rhs_row[j] <= model_rhs[r][j];
            end
            waited = 0;
            do begin
                @(negedge clock);
                waited++;
                if (first_load) begin
                    assert (!lhs_ready) else begin
                        $display("lhs_ready went high before the matrix was complete");
                        errors++;
                    end
                end
            end while (!rhs_ready && waited < wait_limit);
            if (!rhs_ready) begin
                $display("Timeout: rhs_ready never rose for right row %0d", r);
                errors++;
            end
        end
        @(posedge clock);
        rhs_valid <= 1'b0;
    endtask

    // Sends one tile and checks its four rows against the CSR rule
    task automatic run_job(input bit short_tile, input bit stalls);
        int waited;
        int got;
        int p;
        int lo;
        int limit;
        logic [data_w-1:0]          t_data [dim];
        logic [idx_w-1:0]           t_col [dim];
        int                         t_ptr [dim];
        logic [dim-1:0][data_w-1:0] expect_rows [beats];
        @(posedge clock);
        p = 0;
        limit = short_tile ? int'($urandom % dim) : dim;
        for (int k = 0; k < dim; k++) begin
            t_data[k] = data_w'($urandom);
            t_col[k] = idx_w'($urandom);
            lhs_data[k] <= t_data[k];
            lhs_col[k] <= t_col[k];
        end
        // Short tiles always leave row 1 empty
        for (int r = 0; r < dim; r++) begin
            if (!(short_tile && r == 1)) begin
                p = p + int'($urandom % (limit - p + 1));
            end
            t_ptr[r] = p;
            lhs_ptr[r] <= ptr_w'(p);
        end
        lo = 0;
        for (int r = 0; r < beats; r++) begin
            expect_rows[r] = '0;
            for (int k = lo; k < t_ptr[r]; k++) begin
                for (int j = 0; j < dim; j++) begin
                    expect_rows[r][j] = expect_rows[r][j] + t_data[k] * model_rhs[t_col[k]][j];
                end
            end
            lo = t_ptr[r];
        end
        lhs_valid <= 1'b1;
        waited = 0;
        do begin
            @(negedge clock);
            waited++;
        end while (!lhs_ready && waited < wait_limit);
        if (!lhs_ready) begin
            $display("Timeout: lhs_ready never rose for a new tile");
            errors++;
        end
        @(posedge clock);
        lhs_valid <= 1'b0;
        got = 0;
        waited = 0;
        while (got < beats && waited < wait_limit) begin
            @(posedge clock);
            out_ready <= stalls ? ($urandom % 3 != 0) : 1'b1;
            @(negedge clock);
            waited++;
            assert (!lhs_ready && !rhs_ready) else begin
                $display("An input ready was high while output row %0d was pending", got);
                errors++;
            end
            if (out_valid && out_ready) begin
                assert (out_row == expect_rows[got]) else begin
                    $display("Mismatch at %0t: out_row[%0d] expected %h, got %h",
                             $time, got, expect_rows[got], out_row);
                    errors++;
                end
                got++;
            end
        end
        if (got < beats) begin
            $display("Timeout: only %0d of %0d output rows arrived", got, beats);
            errors++;
        end
        @(posedge clock);
        out_ready <= 1'b0;
        @(negedge clock);
        assert (!out_valid) else begin
            $display("out_valid stayed high after the fourth row of a job");
            errors++;
        end
    endtask

    task automatic report_test(input string name);
        int test_errors;
        // Bound assertion failures count against the test that was running
        errors = errors + uut.u_chk.failures - chk_failures;
        chk_failures = uut.u_chk.failures;
        test_errors = errors - test_start;
        if (test_errors != 0) begin
            failed_tests++;
        end
        $display("Test %-28s %s (%0d errors)", name, (test_errors == 0) ? "ok" : "FAILED",
                 test_errors);
        test_start = errors;
    endtask

    initial begin
        void'($urandom(32'h727fdae9));
        errors = 0;
        failed_tests = 0;
        test_start = 0;
        chk_failures = 0;
        reset <= 1'b1;
        rhs_valid <= 1'b0;
        rhs_row <= '0;
        lhs_valid <= 1'b0;
        lhs_data <= '0;
        lhs_col <= '0;
        lhs_ptr <= '0;
        out_ready <= 1'b0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        assert (rhs_ready && !lhs_ready && !out_valid) else begin
            $display("Handshake outputs wrong after reset");
            errors++;
        end
        load_matrix(1'b1);
        @(negedge clock);
        assert (lhs_ready) else begin
            $display("lhs_ready stayed low after a full right matrix");
            errors++;
        end
        report_test("reset and first load");

        repeat (20) run_job(1'b0, 1'b0);
        report_test("random jobs");

        repeat (8) run_job(1'b1, 1'b0);
        report_test("empty and ignored rows");

        repeat (8) run_job(1'b0, 1'b1);
        report_test("output stalls");

        // Fresh matrix before every job
        repeat (4) begin
            load_matrix(1'b0);
            run_job(1'b0, 1'b1);
        end
        report_test("matrix reload");

        $display("Tests run: 5, tests failed: %0d, errors: %0d", failed_tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: spmm_chk.sv
`timescale 1ns/100ps

module spmm_chk
    import spmm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        lhs_ready,
    input  logic                        rhs_ready,
    input  logic                        out_valid,
    input  logic                        out_ready,
    input  logic [dim-1:0][data_w-1:0]  out_row
);

    // Number of assertion failures so far
    int failures = 0;

    // Stalled row holds its value until taken
    stall_holds_row: assert property (
        @(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_row))
    ) else begin
        $error("out_row changed or dropped while the sink was stalling");
        failures++;
    end

    // No new tile while results are still draining
    no_tile_during_drain: assert property (
        @(posedge clock) disable iff (reset)
        !(lhs_ready && out_valid)
    ) else begin
        $error("lhs_ready and out_valid high in the same cycle");
        failures++;
    end

    // Right matrix locked while a job drains
    no_load_during_drain: assert property (
        @(posedge clock) disable iff (reset)
        out_valid |-> !rhs_ready
    ) else begin
        $error("rhs_ready high while out_valid is high");
        failures++;
    end

endmodule

// File: spmm_top.sv
`timescale 1ns/100ps

module spmm_top
    import spmm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,

    // Right matrix, one row per beat
    input  logic                        rhs_valid,
    output logic                        rhs_ready,
    input  logic [dim-1:0][data_w-1:0]  rhs_row,

    // Compressed-row tile
    input  logic                        lhs_valid,
    output logic                        lhs_ready,
    input  logic [dim-1:0][data_w-1:0]  lhs_data,
    input  logic [dim-1:0][idx_w-1:0]   lhs_col,
    input  logic [dim-1:0][ptr_w-1:0]   lhs_ptr,

    // Result rows
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [dim-1:0][data_w-1:0]  out_row
);

    logic [dim-1:0][beats-1:0][data_w-1:0] rhs_matrix;
    logic                                  rhs_full;
    logic                                  loading;
    logic                                  job_busy;
    logic                                  issue;
    logic [dim-1:0][data_w-1:0]            nz_data;
    logic [dim-1:0][idx_w-1:0]             nz_col;
    logic [dim-1:0][idx_w-1:0]             nz_row;
    logic [dim-1:0]                        nz_keep;
    logic [dim-1:0][dim-1:0][data_w-1:0]   col_sums_all;
    logic [dim-1:0]                        pe_sums_valid;
    logic                                  draining;

    rhs_loader u_loader (
        .clock      (clock),
        .reset      (reset),
        .rhs_valid  (rhs_valid),
        .rhs_ready  (rhs_ready),
        .rhs_row    (rhs_row),
        .job_busy   (job_busy),
        .rhs_matrix (rhs_matrix),
        .rhs_full   (rhs_full),
        .loading    (loading)
    );

    lhs_row_decoder u_decoder (
        .clock     (clock),
        .reset     (reset),
        .lhs_valid (lhs_valid),
        .lhs_ready (lhs_ready),
        .lhs_data  (lhs_data),
        .lhs_col   (lhs_col),
        .lhs_ptr   (lhs_ptr),
        .rhs_full  (rhs_full),
        .loading   (loading),
        .draining  (draining),
        .job_busy  (job_busy),
        .issue     (issue),
        .nz_data   (nz_data),
        .nz_col    (nz_col),
        .nz_row    (nz_row),
        .nz_keep   (nz_keep)
    );

    // One PE per output column
    for (genvar j = 0; j < dim; j++) begin : g_pe
        column_pe u_pe (
            .clock      (clock),
            .reset      (reset),
            .issue      (issue),
            .nz_data    (nz_data),
            .nz_col     (nz_col),
            .nz_row     (nz_row),
            .nz_keep    (nz_keep),
            .rhs_column (rhs_matrix[j]),
            .col_sums   (col_sums_all[j]),
            .sums_valid (pe_sums_valid[j])
        );
    end

    // All PEs run in lockstep, element 0 times the capture
    result_collector u_collector (
        .clock        (clock),
        .reset        (reset),
        .sums_valid   (pe_sums_valid[0]),
        .col_sums_all (col_sums_all),
        .out_valid    (out_valid),
        .out_ready    (out_ready),
        .out_row      (out_row),
        .draining     (draining)
    );

endmodule

// File: result_collector.sv
`timescale 1ns/100ps

module result_collector
    import spmm_pkg::*;
(
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 sums_valid,
    input  logic [dim-1:0][dim-1:0][data_w-1:0]  col_sums_all,
    output logic                                 out_valid,
    input  logic                                 out_ready,
    output logic [dim-1:0][data_w-1:0]           out_row,
    output logic                                 draining
);

    // Held result, row-major
    logic [beats-1:0][dim-1:0][data_w-1:0] result;
    logic [idx_w-1:0]                      row_ptr;
    logic                                  row_taken;
    logic                                  last_row;

    assign row_taken = out_valid && out_ready;
    assign last_row  = (row_ptr == idx_w'(beats - 1));

    // Current row held until the sink takes it
    assign out_row  = result[row_ptr];
    assign draining = out_valid;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            out_valid <= 1'b0;
            row_ptr   <= '0;
        end else if (sums_valid) begin
            out_valid <= 1'b1;
            row_ptr   <= '0;
        end else if (row_taken) begin
            if (last_row) begin
                out_valid <= 1'b0;
                row_ptr   <= '0;
            end else begin
                row_ptr <= row_ptr + 1'b1;
            end
        end
    end

    // Transpose column sums into rows on capture
    always_ff @(posedge clock) begin
        if (sums_valid) begin
            for (int r = 0; r < beats; r++) begin
                for (int j = 0; j < dim; j++) begin
                    result[r][j] <= col_sums_all[j][r];
                end
            end
        end
    end

endmodule

// File: column_pe.sv
`timescale 1ns/100ps

module column_pe
    import spmm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        issue,
    input  logic [dim-1:0][data_w-1:0]  nz_data,
    input  logic [dim-1:0][idx_w-1:0]   nz_col,
    input  logic [dim-1:0][idx_w-1:0]   nz_row,
    input  logic [dim-1:0]              nz_keep,
    input  logic [dim-1:0][data_w-1:0]  rhs_column,
    output logic [dim-1:0][data_w-1:0]  col_sums,
    output logic                        sums_valid
);

    logic [dim-1:0][2*data_w-1:0] prod_wide;
    logic [dim-1:0][data_w-1:0]   prod;
    logic [dim-1:0][idx_w-1:0]    prod_row;
    logic [dim-1:0]               prod_keep;
    logic                         prod_valid;
    logic [dim-1:0][data_w-1:0]   row_sum;

    // Column index picks the matching right-matrix element
    always_comb begin
        for (int k = 0; k < dim; k++) begin
            prod_wide[k] = nz_data[k] * rhs_column[nz_col[k]];
        end
    end

    // Segmented reduction, one linear sum per row
    always_comb begin
        for (int r = 0; r < dim; r++) begin
            row_sum[r] = '0;
            for (int k = 0; k < dim; k++) begin
                if (prod_keep[k] && (prod_row[k] == idx_w'(r))) begin
                    row_sum[r] = row_sum[r] + prod[k];
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            prod_valid <= 1'b0;
            sums_valid <= 1'b0;
        end else begin
            prod_valid <= issue;
            sums_valid <= prod_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (issue) begin
            for (int k = 0; k < dim; k++) begin
                prod[k] <= prod_wide[k][data_w-1:0];
            end
            prod_row  <= nz_row;
            prod_keep <= nz_keep;
        end
        if (prod_valid) begin
            col_sums <= row_sum;
        end
    end

endmodule

// File: lhs_row_decoder.sv
`timescale 1ns/100ps

module lhs_row_decoder
    import spmm_pkg::*;
(
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        lhs_valid,
    output logic                        lhs_ready,
    input  logic [dim-1:0][data_w-1:0]  lhs_data,
    input  logic [dim-1:0][idx_w-1:0]   lhs_col,
    input  logic [dim-1:0][ptr_w-1:0]   lhs_ptr,
    input  logic                        rhs_full,
    input  logic                        loading,
    input  logic                        draining,
    output logic                        job_busy,
    output logic                        issue,
    output logic [dim-1:0][data_w-1:0]  nz_data,
    output logic [dim-1:0][idx_w-1:0]   nz_col,
    output logic [dim-1:0][idx_w-1:0]   nz_row,
    output logic [dim-1:0]              nz_keep
);

    logic                      busy;
    logic                      seen_drain;
    logic                      accept;
    logic [dim-1:0][idx_w-1:0] row_next;
    logic [dim-1:0]            keep_next;

    assign lhs_ready = rhs_full && !busy && !loading;
    assign accept    = lhs_valid && lhs_ready;

    // Busy already in the accept cycle, so no load beat slips in alongside
    assign job_busy = busy || accept;

    // Row of nonzero k is the first r whose pointer exceeds k
    always_comb begin
        for (int k = 0; k < dim; k++) begin
            row_next[k] = '0;
            for (int r = dim - 1; r >= 0; r--) begin
                if (ptr_w'(k) < lhs_ptr[r]) begin
                    row_next[k] = idx_w'(r);
                end
            end
            keep_next[k] = (ptr_w'(k) < lhs_ptr[dim-1]);
        end
    end

    // Job ends once the collector has drained its last row
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            busy       <= 1'b0;
            seen_drain <= 1'b0;
            issue      <= 1'b0;
        end else begin
            issue <= accept;
            if (accept) begin
                busy       <= 1'b1;
                seen_drain <= 1'b0;
            end else if (busy) begin
                if (draining) begin
                    seen_drain <= 1'b1;
                end else if (seen_drain) begin
                    busy       <= 1'b0;
                    seen_drain <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            nz_data <= lhs_data;
            nz_col  <= lhs_col;
            nz_row  <= row_next;
            nz_keep <= keep_next;
        end
    end

endmodule

// File: rhs_loader.sv
`timescale 1ns/100ps

module rhs_loader
    import spmm_pkg::*;
(
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    rhs_valid,
    output logic                                    rhs_ready,
    input  logic [dim-1:0][data_w-1:0]              rhs_row,
    input  logic                                    job_busy,
    output logic [dim-1:0][beats-1:0][data_w-1:0]   rhs_matrix,
    output logic                                    rhs_full,
    output logic                                    loading
);

    logic [idx_w-1:0] row_count;
    logic             accept;

    // Matrix stays fixed while a job reads it
    assign rhs_ready = !job_busy;
    assign accept    = rhs_valid && rhs_ready;

    // Part-way through a matrix
    assign loading = (row_count != '0);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            row_count <= '0;
            rhs_full  <= 1'b0;
        end else if (accept) begin
            row_count <= row_count + 1'b1;
            if (row_count == idx_w'(beats - 1)) begin
                rhs_full <= 1'b1;
            end else if (row_count == '0) begin
                // First beat of a new matrix invalidates the old one
                rhs_full <= 1'b0;
            end
        end
    end

    // Stored column-major so each PE gets one slice
    always_ff @(posedge clock) begin
        if (accept) begin
            for (int j = 0; j < dim; j++) begin
                rhs_matrix[j][row_count] <= rhs_row[j];
            end
        end
    end

endmodule

// File: spmm_pkg.sv
package spmm_pkg;

    // Matrix side, also the number of nonzeros in one tile
    localparam int dim = 4;

    // Element width, all arithmetic wraps to this
    localparam int data_w = 8;

    // Row or column index
    localparam int idx_w = 2;

    // Cumulative row pointer, counts 0 to dim
    localparam int ptr_w = 3;

    // Rows per matrix, one load or output beat each
    localparam int beats = 4;

endpackage
